// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_eth_core -f vlog.f -o tb_eth_core_sim
./obj_dir/tb_eth_core_sim > sim.log
cat sim.log
if grep -qx "TB PASSED" sim.log; then
  exit 0
else
  exit 1
fi

// File: source/eth_buffer.sv
`timescale 1ns/1ns
`default_nettype none

module eth_buffer #(
  parameter int BUFFER_W = 11
) (
  input  logic                clk_i,
  input  logic                w_en_i,
  input  logic [BUFFER_W-1:0] w_addr_i,
  input  logic [7:0]          w_data_i,
  input  logic [BUFFER_W-1:0] r_addr_i,
  output logic [7:0]          r_data_o
);

  logic [7:0] mem [2**BUFFER_W];

  always_ff @(posedge clk_i) begin
    if (w_en_i) mem[w_addr_i] <= w_data_i;
    r_data_o <= mem[r_addr_i]; // One cycle read latency
  end

endmodule

`default_nettype wire

// File: source/eth_core.sv
`timescale 1ns/1ns
`default_nettype none

module eth_core #(
  parameter int BUFFER_W    = 11,
  parameter int PHY_RST_CNT = 1048575
) (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          csr_wen_i,
  input  logic                          csr_ren_i,
  input  eth_pkg::csr_addr_e            csr_addr_i,
  input  logic [eth_pkg::CSR_DATA_W-1:0] csr_wdata_i,
  output logic [eth_pkg::CSR_DATA_W-1:0] csr_rdata_o,
  output logic                          csr_rvalid_o,
  output logic                          mtx_en_o,
  output logic [3:0]                    mtxd_o,
  input  logic                          mrx_dv_i,
  input  logic [3:0]                    mrxd_i,
  output logic                          phy_rstn_o
);

  logic                tx_ready;
  logic                tx_send;
  logic                tx_enable;
  logic                crc_enable;
  logic [BUFFER_W-1:0] tx_nbytes;
  logic                txb_wr;
  logic [BUFFER_W-1:0] txb_waddr;
  logic [7:0]          txb_wdata;
  logic [BUFFER_W-1:0] txb_raddr;
  logic [7:0]          txb_rdata;
  logic                rxb_wr;
  logic [BUFFER_W-1:0] rxb_waddr;
  logic [7:0]          rxb_wdata;
  logic [BUFFER_W-1:0] rxb_raddr;
  logic [7:0]          rxb_rdata;
  logic                rx_done;
  logic [BUFFER_W-1:0] rx_nbytes;
  logic                rx_crc_err;
  logic                rx_enable;
  logic                rx_ack;

  eth_csr #(
    .BUFFER_W   (BUFFER_W),
    .PHY_RST_CNT(PHY_RST_CNT)
  ) u_csr (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .csr_wen_i   (csr_wen_i),
    .csr_ren_i   (csr_ren_i),
    .csr_addr_i  (csr_addr_i),
    .csr_wdata_i (csr_wdata_i),
    .csr_rdata_o (csr_rdata_o),
    .csr_rvalid_o(csr_rvalid_o),
    .tx_ready_i  (tx_ready),
    .tx_send_o   (tx_send),
    .tx_enable_o (tx_enable),
    .crc_enable_o(crc_enable),
    .tx_nbytes_o (tx_nbytes),
    .txb_wr_o    (txb_wr),
    .txb_addr_o  (txb_waddr),
    .txb_data_o  (txb_wdata),
    .rxb_addr_o  (rxb_raddr),
    .rxb_data_i  (rxb_rdata),
    .rx_done_i   (rx_done),
    .rx_nbytes_i (rx_nbytes),
    .rx_crc_err_i(rx_crc_err),
    .rx_enable_o (rx_enable),
    .rx_ack_o    (rx_ack),
    .phy_rstn_o  (phy_rstn_o)
  );

  eth_tx #(.BUFFER_W(BUFFER_W)) u_tx (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .send_i    (tx_send & tx_enable),
    .crc_en_i  (crc_enable),
    .nbytes_i  (tx_nbytes),
    .ready_o   (tx_ready),
    .buf_addr_o(txb_raddr),
    .buf_data_i(txb_rdata),
    .mtx_en_o  (mtx_en_o),
    .mtxd_o    (mtxd_o)
  );

  eth_rx #(.BUFFER_W(BUFFER_W)) u_rx (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .enable_i (rx_enable),
    .ack_i    (rx_ack),
    .mrx_dv_i (mrx_dv_i),
    .mrxd_i   (mrxd_i),
    .wr_o     (rxb_wr),
    .addr_o   (rxb_waddr),
    .data_o   (rxb_wdata),
    .done_o   (rx_done),
    .nbytes_o (rx_nbytes),
    .crc_err_o(rx_crc_err)
  );

  // Host writes, transmitter reads
  eth_buffer #(.BUFFER_W(BUFFER_W)) tx_buffer (
    .clk_i   (clk_i),
    .w_en_i  (txb_wr),
    .w_addr_i(txb_waddr),
    .w_data_i(txb_wdata),
    .r_addr_i(txb_raddr),
    .r_data_o(txb_rdata)
  );

  // Receiver writes, host reads
  eth_buffer #(.BUFFER_W(BUFFER_W)) rx_buffer (
    .clk_i   (clk_i),
    .w_en_i  (rxb_wr),
    .w_addr_i(rxb_waddr),
    .w_data_i(rxb_wdata),
    .r_addr_i(rxb_raddr),
    .r_data_o(rxb_rdata)
  );

endmodule

`default_nettype wire

// File: source/eth_crc32.sv
`timescale 1ns/1ns
`default_nettype none

module eth_crc32 (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        init_i,
  input  logic        en_i,
  input  logic [3:0]  nibble_i,
  output logic [31:0] crc_o,
  output logic        residue_ok_o
);
  import eth_pkg::*;

  localparam logic [31:0] CRC_POLY = 32'hEDB88320; // Reflected 802.3 polynomial

  logic [31:0] crc_q;
  logic [31:0] crc_next;
  logic [31:0] crc_rev;

  // Four serial steps, bit 0 of the nibble goes first as on the wire
  always_comb begin
    crc_next = crc_q;
    for (int i = 0; i < 4; i++) begin
      if (crc_next[0] ^ nibble_i[i]) crc_next = (crc_next >> 1) ^ CRC_POLY;
      else crc_next = crc_next >> 1;
    end
  end

  always_comb begin
    for (int i = 0; i < 32; i++) crc_rev[i] = crc_q[31-i];
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) crc_q <= '1;
    else if (init_i) crc_q <= '1;
    else if (en_i) crc_q <= crc_next;
  end

  // Register is kept reflected, so the inverse is already in wire order
  assign crc_o        = ~crc_q;
  assign residue_ok_o = (crc_rev == CRC_RESIDUE);

endmodule

`default_nettype wire

// File: source/eth_csr.sv
`timescale 1ns/1ns
`default_nettype none

module eth_csr #(
  parameter int BUFFER_W    = 11,
  parameter int PHY_RST_CNT = 1048575
) (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          csr_wen_i,
  input  logic                          csr_ren_i,
  input  eth_pkg::csr_addr_e            csr_addr_i,
  input  logic [eth_pkg::CSR_DATA_W-1:0] csr_wdata_i,
  output logic [eth_pkg::CSR_DATA_W-1:0] csr_rdata_o,
  output logic                          csr_rvalid_o,
  input  logic                          tx_ready_i,
  output logic                          tx_send_o,
  output logic                          tx_enable_o,
  output logic                          crc_enable_o,
  output logic [BUFFER_W-1:0]           tx_nbytes_o,
  output logic                          txb_wr_o,
  output logic [BUFFER_W-1:0]           txb_addr_o,
  output logic [7:0]                    txb_data_o,
  output logic [BUFFER_W-1:0]           rxb_addr_o,
  input  logic [7:0]                    rxb_data_i,
  input  logic                          rx_done_i,
  input  logic [BUFFER_W-1:0]           rx_nbytes_i,
  input  logic                          rx_crc_err_i,
  output logic                          rx_enable_o,
  output logic                          rx_ack_o,
  output logic                          phy_rstn_o
);
  import eth_pkg::*;

  localparam int PHY_CNT_W = $clog2(PHY_RST_CNT + 1);

  logic [2:0]            moder_q;
  logic [BUFFER_W-1:0]   nbytes_q;
  logic [BUFFER_W-1:0]   ptr_q;      // Buffer window pointer
  logic [PHY_CNT_W-1:0]  phy_cnt_q;
  logic                  buf_rd_q;   // Receive buffer read in flight
  logic                  wr_tx_data;
  logic                  rd_rx_data;
  logic [CSR_DATA_W-1:0] rdata_mux;

  assign wr_tx_data = csr_wen_i && (csr_addr_i == CSR_TX_DATA);
  assign rd_rx_data = csr_ren_i && (csr_addr_i == CSR_RX_DATA);

  assign tx_enable_o  = moder_q[0];
  assign rx_enable_o  = moder_q[1];
  assign crc_enable_o = moder_q[2];
  assign tx_nbytes_o  = nbytes_q;

  assign txb_wr_o   = wr_tx_data;
  assign txb_addr_o = ptr_q;
  assign txb_data_o = csr_wdata_i[7:0];
  assign rxb_addr_o = ptr_q;

  always_comb begin
    case (csr_addr_i)
      CSR_MODER:     rdata_mux = CSR_DATA_W'(moder_q);
      CSR_TX_NBYTES: rdata_mux = CSR_DATA_W'(nbytes_q);
      CSR_STATUS:    rdata_mux = CSR_DATA_W'({!phy_rstn_o, rx_crc_err_i, rx_done_i,
                                              tx_ready_i & !tx_send_o});
      CSR_RX_NBYTES: rdata_mux = rx_done_i ? CSR_DATA_W'(rx_nbytes_i) : '0;
      CSR_BUF_ADDR:  rdata_mux = CSR_DATA_W'(ptr_q);
      default:       rdata_mux = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (buf_rd_q) csr_rdata_o <= CSR_DATA_W'(rxb_data_i);
    else if (csr_ren_i) csr_rdata_o <= rdata_mux;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      moder_q      <= '0;
      nbytes_q     <= '0;
      ptr_q        <= '0;
      tx_send_o    <= 1'b0;
      rx_ack_o     <= 1'b0;
      buf_rd_q     <= 1'b0;
      csr_rvalid_o <= 1'b0;
      phy_cnt_q    <= PHY_CNT_W'(PHY_RST_CNT);
      phy_rstn_o   <= 1'b0;
    end else begin
      // Extra send strobes are dropped while the transmitter is busy
      tx_send_o <= csr_wen_i && (csr_addr_i == CSR_SEND) && tx_ready_i && moder_q[0]
                   && !tx_send_o;
      rx_ack_o  <= csr_wen_i && (csr_addr_i == CSR_RX_ACK);
      if (csr_wen_i) begin
        case (csr_addr_i)
          CSR_MODER:     moder_q  <= csr_wdata_i[2:0];
          CSR_TX_NBYTES: nbytes_q <= csr_wdata_i[BUFFER_W-1:0];
          CSR_BUF_ADDR:  ptr_q    <= csr_wdata_i[BUFFER_W-1:0];
          default: ;
        endcase
      end
      if (wr_tx_data || rd_rx_data) ptr_q <= ptr_q + 1'b1; // Auto increment

      buf_rd_q     <= rd_rx_data;
      csr_rvalid_o <= (csr_ren_i && !rd_rx_data) || buf_rd_q;

      if (phy_cnt_q != '0) phy_cnt_q <= phy_cnt_q - 1'b1;
      phy_rstn_o <= (phy_cnt_q == '0);
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_n_i) !(csr_wen_i && csr_ren_i));

  // Transmitter must be idle when a frame is started
  assert property (@(posedge clk_i) disable iff (!rst_n_i) tx_send_o |-> tx_ready_i);

endmodule

`default_nettype wire

// File: source/eth_pkg.sv
`default_nettype none

package eth_pkg;

  parameter int CSR_ADDR_W = 4;
  parameter int CSR_DATA_W = 32;

  // Host register map
  typedef enum logic [CSR_ADDR_W-1:0] {
    CSR_MODER     = 4'd0, // [0] tx en, [1] rx en, [2] append CRC
    CSR_TX_NBYTES = 4'd1,
    CSR_SEND      = 4'd2, // Write strobe
    CSR_STATUS    = 4'd3, // [0] tx ready, [1] rx done, [2] crc err, [3] phy rst
    CSR_RX_NBYTES = 4'd4,
    CSR_BUF_ADDR  = 4'd5,
    CSR_TX_DATA   = 4'd6,
    CSR_RX_DATA   = 4'd7,
    CSR_RX_ACK    = 4'd8  // Write strobe
  } csr_addr_e;

  typedef enum logic [2:0] {
    TX_IDLE,
    TX_PREAMBLE,
    TX_DATA,
    TX_FCS,
    TX_IPG
  } tx_state_e;

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_PREAMBLE,
    RX_DATA,
    RX_DONE
  } rx_state_e;

  parameter logic [3:0] PREAMBLE_NIBBLE = 4'h5;
  parameter logic [3:0] SFD_HIGH_NIBBLE = 4'hD;
  parameter int IPG_CYCLES = 24; // 12 byte times at one nibble per clock

  // Good frame plus FCS leaves this behind
  parameter logic [31:0] CRC_RESIDUE = 32'hC704DD7B;

endpackage

`default_nettype wire

// File: source/eth_rx.sv
`timescale 1ns/1ns
`default_nettype none

module eth_rx #(
  parameter int BUFFER_W = 11
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                enable_i,
  input  logic                ack_i,
  input  logic                mrx_dv_i,
  input  logic [3:0]          mrxd_i,
  output logic                wr_o,
  output logic [BUFFER_W-1:0] addr_o,
  output logic [7:0]          data_o,
  output logic                done_o,
  output logic [BUFFER_W-1:0] nbytes_o,
  output logic                crc_err_o
);
  import eth_pkg::*;

  rx_state_e           state_q;
  logic                hi_q;      // Next nibble completes a byte
  logic [3:0]          lo_nib_q;
  logic [BUFFER_W-1:0] ptr_q;
  logic                sfd_seen;
  logic                nib_en;
  logic                crc_ok;

  assign sfd_seen = (state_q == RX_PREAMBLE) && mrx_dv_i && (mrxd_i == SFD_HIGH_NIBBLE);
  assign nib_en   = (state_q == RX_DATA) && mrx_dv_i;

  assign wr_o   = nib_en && hi_q;
  assign addr_o = ptr_q;
  assign data_o = {mrxd_i, lo_nib_q};

  // FCS nibbles go through too and leave the residue behind
  eth_crc32 u_crc (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .init_i      (sfd_seen),
    .en_i        (nib_en),
    .nibble_i    (mrxd_i),
    .crc_o       (),
    .residue_ok_o(crc_ok)
  );

  always_ff @(posedge clk_i) begin
    if (nib_en && !hi_q) lo_nib_q <= mrxd_i;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q   <= RX_IDLE;
      hi_q      <= 1'b0;
      ptr_q     <= '0;
      done_o    <= 1'b0;
      nbytes_o  <= '0;
      crc_err_o <= 1'b0;
    end else begin
      case (state_q)
        RX_IDLE: if (enable_i && mrx_dv_i) state_q <= RX_PREAMBLE;
        RX_PREAMBLE: begin
          if (!mrx_dv_i || !enable_i) begin
            state_q <= RX_IDLE;
          end else if (sfd_seen) begin
            state_q <= RX_DATA;
            hi_q    <= 1'b0;
            ptr_q   <= '0;
          end
        end
        RX_DATA: begin
          if (mrx_dv_i) begin
            hi_q <= !hi_q;
            if (hi_q) ptr_q <= ptr_q + 1'b1;
          end else begin
            state_q   <= RX_DONE;            // Held until the host acks
            done_o    <= 1'b1;
            nbytes_o  <= ptr_q;
            crc_err_o <= !crc_ok;
          end
        end
        RX_DONE: if (ack_i) begin
          state_q   <= RX_IDLE;
          done_o    <= 1'b0;
          nbytes_o  <= '0;
          crc_err_o <= 1'b0;
        end
        default: state_q <= RX_IDLE;
      endcase
    end
  end

  // Stored frame stays untouched until acknowledged
  assert property (@(posedge clk_i) disable iff (!rst_n_i) done_o |-> !wr_o);

endmodule

`default_nettype wire

// File: source/eth_tx.sv
`timescale 1ns/1ns
`default_nettype none

module eth_tx #(
  parameter int BUFFER_W = 11
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                send_i,
  input  logic                crc_en_i,
  input  logic [BUFFER_W-1:0] nbytes_i,
  output logic                ready_o,
  output logic [BUFFER_W-1:0] buf_addr_o,
  input  logic [7:0]          buf_data_i,
  output logic                mtx_en_o,
  output logic [3:0]          mtxd_o
);
  import eth_pkg::*;

  tx_state_e           state_q;
  logic [4:0]          cnt_q;     // Preamble, FCS and gap counter
  logic                hi_q;      // High nibble is on the wire
  logic                crc_en_q;
  logic [BUFFER_W-1:0] nbytes_q;
  logic                sfd_out;
  logic                last_byte;
  logic                load_lo;
  logic                load_hi;
  logic                data_end;
  logic                crc_init;
  logic [31:0]         fcs;

  assign sfd_out   = (state_q == TX_PREAMBLE) && (cnt_q == 5'd15);
  assign last_byte = (buf_addr_o == nbytes_q); // Address runs one byte ahead
  assign load_lo   = (sfd_out && nbytes_q != '0) || (state_q == TX_DATA && hi_q && !last_byte);
  assign load_hi   = (state_q == TX_DATA) && !hi_q;
  assign data_end  = (sfd_out && nbytes_q == '0) || (state_q == TX_DATA && hi_q && last_byte);
  assign crc_init  = (state_q == TX_IDLE) && send_i;
  assign ready_o   = (state_q == TX_IDLE);

  eth_crc32 u_crc (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .init_i      (crc_init),
    .en_i        (load_lo | load_hi),
    .nibble_i    (load_lo ? buf_data_i[3:0] : buf_data_i[7:4]),
    .crc_o       (fcs),
    .residue_ok_o()
  );

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q    <= TX_IDLE;
      cnt_q      <= '0;
      hi_q       <= 1'b0;
      crc_en_q   <= 1'b0;
      nbytes_q   <= '0;
      buf_addr_o <= '0;
      mtx_en_o   <= 1'b0;
      mtxd_o     <= '0;
    end else begin
      case (state_q)
        TX_IDLE: if (send_i) begin
          state_q    <= TX_PREAMBLE;
          cnt_q      <= '0;
          nbytes_q   <= nbytes_i;
          crc_en_q   <= crc_en_i;
          buf_addr_o <= '0;           // First byte fetched during preamble
          mtx_en_o   <= 1'b1;
          mtxd_o     <= PREAMBLE_NIBBLE;
        end
        TX_PREAMBLE: begin
          cnt_q  <= cnt_q + 5'd1;
          mtxd_o <= (cnt_q == 5'd14) ? SFD_HIGH_NIBBLE : PREAMBLE_NIBBLE;
          if (load_lo) state_q <= TX_DATA;
        end
        TX_FCS: begin
          if (cnt_q == 5'd8) begin
            state_q  <= TX_IPG;
            cnt_q    <= '0;
            mtx_en_o <= 1'b0;
            mtxd_o   <= '0;
          end else begin
            mtxd_o <= fcs[{cnt_q[2:0], 2'b00} +: 4];
            cnt_q  <= cnt_q + 5'd1;
          end
        end
        TX_IPG: begin
          if (cnt_q == 5'(IPG_CYCLES - 1)) state_q <= TX_IDLE;
          else cnt_q <= cnt_q + 5'd1;
        end
        TX_DATA: ;                     // Nibble loads below
        default: state_q <= TX_IDLE;
      endcase

      // Payload nibbles, low half first
      if (load_lo) begin
        mtxd_o     <= buf_data_i[3:0];
        hi_q       <= 1'b0;
        buf_addr_o <= buf_addr_o + 1'b1;
      end
      if (load_hi) begin
        mtxd_o <= buf_data_i[7:4];
        hi_q   <= 1'b1;
      end
      if (data_end) begin
        if (crc_en_q) begin
          state_q <= TX_FCS;
          mtxd_o  <= fcs[3:0];
          cnt_q   <= 5'd1;
        end else begin
          state_q  <= TX_IPG;
          cnt_q    <= '0;
          mtx_en_o <= 1'b0;
          mtxd_o   <= '0;
        end
      end
    end
  end

  // Line must be quiet outside a frame
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (state_q inside {TX_IDLE, TX_IPG}) |-> !mtx_en_o);

endmodule

`default_nettype wire

// File: tests/tb_eth_core.sv
`timescale 1ns/1ns
`default_nettype none

module tb_eth_core;
  import eth_pkg::*;

  localparam int BUFFER_W    = 11;
  localparam int PHY_RST_CNT = 16;
  localparam int READ_WAIT   = 8;    // Cycles allowed for csr_rvalid_o
  localparam int WAIT_POLLS  = 200;  // Status polls per wait
  localparam int QUIET_POLLS = 60;   // Outlasts the longest gated frame
  localparam int CORRUPT_NIB = 19;   // High nibble of payload byte 1
  localparam int NROWS       = 8;

  typedef struct packed {
    logic [BUFFER_W-1:0] len;
    logic                tx_en;
    logic                rx_en;
    logic                crc_en;
    logic                corrupt;
    logic                exp_done;
    logic                exp_err;
  } row_t;

  // len, tx en, rx en, crc en, corrupt, rx done expected, crc error expected
  localparam row_t ROWS [NROWS] = '{
    '{11'd8,  1'b1, 1'b1, 1'b1, 1'b0, 1'b1, 1'b0},
    '{11'd46, 1'b1, 1'b1, 1'b1, 1'b0, 1'b1, 1'b0},
    '{11'd1,  1'b1, 1'b1, 1'b1, 1'b0, 1'b1, 1'b0},
    '{11'd20, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1},
    '{11'd16, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1, 1'b1}, // Without FCS the residue cannot match
    '{11'd12, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0}, // Send ignored
    '{11'd12, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0}, // Receiver off
    '{11'd30, 1'b1, 1'b1, 1'b1, 1'b0, 1'b1, 1'b0}
  };

  logic                  clk;
  logic                  rst_n     = 1'b0;
  logic                  csr_wen   = 1'b0;
  logic                  csr_ren   = 1'b0;
  csr_addr_e             csr_addr  = CSR_MODER;
  logic [CSR_DATA_W-1:0] csr_wdata = '0;
  logic [CSR_DATA_W-1:0] csr_rdata;
  logic                  csr_rvalid;
  logic                  mtx_en;
  logic [3:0]            mtxd;
  logic                  mrx_dv    = 1'b0;
  logic [3:0]            mrxd      = 4'h0;
  logic                  phy_rstn;

  logic                  corrupt_q = 1'b0;
  int                    nib_idx   = 0;
  int                    bursts    = 0;  // Frames seen on mtx_en
  int                    burst_len = 0;  // Length of the last one in cycles
  int                    cycle_cnt = 0;
  int                    errors    = 0;
  int                    timeouts  = 0;
  logic [15:0]           lfsr_q    = 16'd24;

  eth_core #(
    .BUFFER_W   (BUFFER_W),
    .PHY_RST_CNT(PHY_RST_CNT)
  ) dut0 (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .csr_wen_i   (csr_wen),
    .csr_ren_i   (csr_ren),
    .csr_addr_i  (csr_addr),
    .csr_wdata_i (csr_wdata),
    .csr_rdata_o (csr_rdata),
    .csr_rvalid_o(csr_rvalid),
    .mtx_en_o    (mtx_en),
    .mtxd_o      (mtxd),
    .mrx_dv_i    (mrx_dv),
    .mrxd_i      (mrxd),
    .phy_rstn_o  (phy_rstn)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // MII loopback that may flip one payload nibble
  always @(posedge clk) begin
    nib_idx <= mtx_en ? nib_idx + 1 : 0;
    mrx_dv  <= mtx_en;
    mrxd    <= mtxd ^ ((corrupt_q && mtx_en && nib_idx == CORRUPT_NIB) ? 4'h1 : 4'h0);
    if (mtx_en && nib_idx < 16) begin
      check_byte({4'h0, mtxd},
                 {4'h0, (nib_idx == 15) ? SFD_HIGH_NIBBLE : PREAMBLE_NIBBLE},
                 $sformatf("preamble nibble %0d", nib_idx));
    end
    if (!mtx_en && nib_idx != 0) begin // Frame just ended
      burst_len <= nib_idx;
      bursts    <= bursts + 1;
    end
  end

  always @(posedge clk) begin
    if (!rst_n) cycle_cnt <= 0;
    else cycle_cnt <= cycle_cnt + 1; // Cycles since reset release
  end

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10]; // x^16 + x^14 + x^13 + x^11 + 1
    return {s[14:0], fb};
  endfunction

  task automatic next_payload_byte(output logic [7:0] b);
    b = '0;
    for (int i = 0; i < 8; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      b      = {b[6:0], lfsr_q[0]};
    end
  endtask

  task automatic check_word(input logic [CSR_DATA_W-1:0] got, input logic [CSR_DATA_W-1:0] exp,
                            input string what);
    if (got !== exp) begin
      $display("FAILED %0t ns: %s got 0x%0h expected 0x%0h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
    if (got !== exp) begin
      $display("FAILED %0t ns: %s got 0x%02h expected 0x%02h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic csr_write(input csr_addr_e addr, input logic [CSR_DATA_W-1:0] data);
    @(posedge clk);
    csr_wen   <= 1'b1;
    csr_addr  <= addr;
    csr_wdata <= data;
    @(posedge clk);
    csr_wen   <= 1'b0;
  endtask

  task automatic csr_read(input csr_addr_e addr, output logic [CSR_DATA_W-1:0] data);
    int  n;
    bit  got;
    n    = 0;
    got  = 1'b0;
    data = 'x;
    @(posedge clk);
    csr_ren  <= 1'b1;
    csr_addr <= addr;
    @(posedge clk);
    csr_ren  <= 1'b0;
    while (!got && n < READ_WAIT) begin
      @(negedge clk); // Away from the edge that updates rvalid
      if (csr_rvalid) begin
        data = csr_rdata;
        got  = 1'b1;
      end
      n++;
    end
    if (!got) begin
      $display("ERROR: read of register %s was never answered", addr.name());
      timeouts++;
    end
  endtask

  task automatic wait_status(input int bit_idx, input logic val, input string what);
    logic [CSR_DATA_W-1:0] d;
    int                    n;
    bit                    seen;
    n    = 0;
    seen = 1'b0;
    while (!seen && n < WAIT_POLLS) begin
      csr_read(CSR_STATUS, d);
      seen = (d[bit_idx] === val);
      n++;
    end
    if (!seen) begin
      $display("ERROR: timeout, %s never came", what);
      timeouts++;
    end
  endtask

  task automatic run_row(input row_t row, input int idx);
    logic [7:0]            payload [$];
    logic [7:0]            b;
    logic [CSR_DATA_W-1:0] d;
    logic [CSR_DATA_W-1:0] exp_cnt;
    bit                    seen;
    int                    bursts_before;
    bursts_before = bursts;
    corrupt_q <= row.corrupt;
    csr_write(CSR_MODER, CSR_DATA_W'({row.crc_en, row.rx_en, row.tx_en}));
    csr_write(CSR_BUF_ADDR, '0);
    for (int i = 0; i < int'(row.len); i++) begin
      next_payload_byte(b);
      payload.push_back(b);
      csr_write(CSR_TX_DATA, CSR_DATA_W'(b));
    end
    csr_write(CSR_TX_NBYTES, CSR_DATA_W'(row.len));
    wait_status(0, 1'b1, $sformatf("tx ready before send, row %0d", idx));
    csr_write(CSR_SEND, '0);

    if (row.exp_done) begin
      wait_status(1, 1'b1, $sformatf("rx done, row %0d", idx));
      csr_read(CSR_STATUS, d);
      check_word(d & 32'h6, CSR_DATA_W'({row.exp_err, 2'b10}),
                 $sformatf("row %0d status rx bits", idx));
      exp_cnt = CSR_DATA_W'(row.len) + (row.crc_en ? 32'd4 : 32'd0);
      csr_read(CSR_RX_NBYTES, d);
      check_word(d, exp_cnt, $sformatf("row %0d rx byte count", idx));
      if (!row.corrupt) begin
        csr_write(CSR_BUF_ADDR, '0);
        for (int i = 0; i < int'(row.len); i++) begin
          csr_read(CSR_RX_DATA, d);
          check_byte(d[7:0], payload[i], $sformatf("row %0d rx byte %0d", idx, i));
        end
      end
      csr_write(CSR_RX_ACK, '0);
      csr_read(CSR_STATUS, d);
      check_word(d & 32'h6, '0, $sformatf("row %0d status after ack", idx));
      csr_read(CSR_RX_NBYTES, d);
      check_word(d, '0, $sformatf("row %0d byte count after ack", idx));
    end else begin
      seen = 1'b0;
      for (int n = 0; n < QUIET_POLLS; n++) begin
        csr_read(CSR_STATUS, d);
        if (d[1] === 1'b1) seen = 1'b1;
      end
      check_word(CSR_DATA_W'(seen), '0, $sformatf("row %0d rx done while gated", idx));
    end
    wait_status(0, 1'b1, $sformatf("tx idle after row %0d", idx)); // Line quiet again

    // 16 preamble nibbles, two per byte, eight more with FCS
    check_word(CSR_DATA_W'(bursts - bursts_before), CSR_DATA_W'(row.tx_en),
               $sformatf("row %0d frames on the line", idx));
    if (row.tx_en) begin
      check_word(CSR_DATA_W'(burst_len),
                 CSR_DATA_W'(16 + 2 * int'(row.len) + (row.crc_en ? 8 : 0)),
                 $sformatf("row %0d mtx_en cycles", idx));
    end
  endtask

  initial begin
    logic [CSR_DATA_W-1:0] d;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;

    // PHY reset counter
    csr_read(CSR_STATUS, d);
    check_word(d & 32'h8, 32'h8, "status phy in reset");
    while (!phy_rstn && cycle_cnt < PHY_RST_CNT + 5) @(negedge clk);
    if (!phy_rstn) begin
      $display("ERROR: timeout, phy_rstn_o never rose");
      timeouts++;
    end
    csr_read(CSR_STATUS, d);
    check_word(d & 32'h8, '0, "status phy released");

    csr_write(CSR_MODER, 32'h7);
    csr_read(CSR_MODER, d);
    check_word(d, 32'h7, "moder readback");
    csr_write(CSR_TX_NBYTES, 32'd37);
    csr_read(CSR_TX_NBYTES, d);
    check_word(d, 32'd37, "tx nbytes readback");
    csr_read(CSR_STATUS, d);
    check_word(d, 32'h1, "status after reset");
    csr_read(CSR_RX_NBYTES, d);
    check_word(d, '0, "rx nbytes after reset");

    for (int r = 0; r < NROWS; r++) run_row(ROWS[r], r);

    $display("Errors: %0d wrong values, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
source/eth_pkg.sv
source/eth_buffer.sv
source/eth_crc32.sv
source/eth_tx.sv
source/eth_rx.sv
source/eth_csr.sv
source/eth_core.sv
tests/tb_eth_core.sv
